// File: build.f
design/hyper_bus_pkg.sv
design/hyper_regs_pkg.sv
design/hyper_cycle_counter.sv
design/hyper_data_shifter.sv
design/hyper_xfer_fsm.sv
design/hyper_apb_regs.sv
design/hyper_top.sv
sim/tb_clock_gen.sv
sim/hyper_mem_model.sv
sim/tb_hyper_top.sv

// File: design/hyper_apb_regs.sv
// APB slave without wait states; a start while busy or an unmapped offset errors and is ignored
`timescale 1ns/1ns

module hyper_apb_regs (
   input  logic                              ref_clk,
   input  logic                              rst_n,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [hyper_regs_pkg::ADDR_W-1:0] paddr,
   input  logic [hyper_regs_pkg::DATA_W-1:0] pwdata,
   output logic [hyper_regs_pkg::DATA_W-1:0] prdata,
   output logic                              pready,
   output logic                              pslverr,
   input  logic                              busy,
   input  logic                              done_pulse,
   input  logic [hyper_regs_pkg::DATA_W-1:0] rdata_word,
   input  logic                              rdata_valid,
   output logic                              start,
   output logic                              write,
   output logic [hyper_regs_pkg::DATA_W-1:0] addr,
   output logic [hyper_regs_pkg::DATA_W-1:0] wdata
);

   logic                              access;
   logic                              mapped;
   logic                              busy_err;
   logic                              wr_en;
   logic                              wr_ctrl;
   logic                              write_q;
   logic                              done_q;
   logic [hyper_regs_pkg::DATA_W-1:0] rdata_q;

   // -------------------------------------------------------------------------
   // Decode of the access cycle
   // -------------------------------------------------------------------------

   assign access = psel & penable;

   always_comb begin
      case (paddr)
         hyper_regs_pkg::REG_CTRL,
         hyper_regs_pkg::REG_ADDR,
         hyper_regs_pkg::REG_WDATA,
         hyper_regs_pkg::REG_RDATA,
         hyper_regs_pkg::REG_STATUS: mapped = 1'b1;
         default:                    mapped = 1'b0;
      endcase
   end

   // A second start cannot queue behind the running transfer
   assign busy_err = pwrite & (paddr == hyper_regs_pkg::REG_CTRL) &
                     pwdata[hyper_regs_pkg::CTRL_START_BIT] & busy;

   assign pready  = 1'b1;
   assign pslverr = access & (~mapped | busy_err);

   // Only error-free writes touch the registers
   assign wr_en   = access & pwrite & ~pslverr;
   assign wr_ctrl = wr_en & (paddr == hyper_regs_pkg::REG_CTRL);

   // Start is a single cycle pulse because the access cycle lasts one clock
   assign start = wr_ctrl & pwdata[hyper_regs_pkg::CTRL_START_BIT];

   // The direction must be valid on the same edge that takes the start
   assign write = wr_ctrl ? pwdata[hyper_regs_pkg::CTRL_WRITE_BIT] : write_q;

   // -------------------------------------------------------------------------
   // Register storage
   // -------------------------------------------------------------------------

   always_ff @(posedge ref_clk) begin
      if (!rst_n) begin
         write_q <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         if (wr_ctrl) write_q <= pwdata[hyper_regs_pkg::CTRL_WRITE_BIT];
         // Sticky done, cleared by the start that launches the next transfer
         if (start) done_q <= 1'b0;
         else if (done_pulse) done_q <= 1'b1;
      end
   end

   always_ff @(posedge ref_clk) begin
      if (wr_en && paddr == hyper_regs_pkg::REG_ADDR) addr <= pwdata;
      if (wr_en && paddr == hyper_regs_pkg::REG_WDATA) wdata <= pwdata;
      if (rdata_valid) rdata_q <= rdata_word;
   end

   // Read mux, answered combinationally in the access cycle
   always_comb begin
      prdata = '0;
      case (paddr)
         hyper_regs_pkg::REG_CTRL:  prdata[hyper_regs_pkg::CTRL_WRITE_BIT] = write_q;
         hyper_regs_pkg::REG_ADDR:  prdata = addr;
         hyper_regs_pkg::REG_WDATA: prdata = wdata;
         hyper_regs_pkg::REG_RDATA: prdata = rdata_q;
         hyper_regs_pkg::REG_STATUS: begin
            prdata[hyper_regs_pkg::STAT_BUSY_BIT] = busy;
            prdata[hyper_regs_pkg::STAT_DONE_BIT] = done_q;
         end
         default: prdata = '0;
      endcase
   end

endmodule

// File: design/hyper_bus_pkg.sv
// HyperBus protocol constants for a single data rate, single chip select link with fixed latency
package hyper_bus_pkg;

   // -------------------------------------------------------------------------
   // Transfer sequencing
   // -------------------------------------------------------------------------

   // One state per bus phase, plus idle and a one cycle completion state
   typedef enum logic [2:0] {
      IDLE = 3'd0,
      CMD  = 3'd1,
      LAT  = 3'd2,
      DATA = 3'd3,
      DONE = 3'd4
   } xfer_state_e;

   // Phase code shared by the FSM, the phase counter and the data shifter
   // IDLE and DONE report PH_CMD, which nothing acts on outside a phase
   typedef enum logic [1:0] {
      PH_CMD  = 2'd0,
      PH_LAT  = 2'd1,
      PH_DATA = 2'd2
   } phase_e;

   // -------------------------------------------------------------------------
   // Fixed byte counts
   // -------------------------------------------------------------------------

   // Command/address word is 48 bits, sent one byte per clock
   localparam int unsigned CA_BYTES = 6;

   // Exactly one 32-bit word per command, no bursts
   localparam int unsigned DATA_BYTES = 4;

   // Phase counter width, which caps LATENCY at 256 cycles
   localparam int unsigned CNT_W = 8;
   typedef logic [CNT_W-1:0] cnt_t;

endpackage

// File: design/hyper_cycle_counter.sv
// Phase length counter; LATENCY must lie between 1 and 256
`timescale 1ns/1ns

module hyper_cycle_counter #(
   parameter int unsigned LATENCY = 6
) (
   input  logic                  ref_clk,
   input  logic                  rst_n,
   input  logic                  load,
   input  hyper_bus_pkg::phase_e phase,
   output logic                  last
);

   hyper_bus_pkg::cnt_t len;
   hyper_bus_pkg::cnt_t remaining;
   hyper_bus_pkg::cnt_t cnt_q;

   // Length in cycles of the phase being entered
   always_comb begin
      case (phase)
         hyper_bus_pkg::PH_LAT:  len = hyper_bus_pkg::cnt_t'(LATENCY);
         hyper_bus_pkg::PH_DATA: len = hyper_bus_pkg::cnt_t'(hyper_bus_pkg::DATA_BYTES);
         default:                len = hyper_bus_pkg::cnt_t'(hyper_bus_pkg::CA_BYTES);
      endcase
   end

   // Load arrives in the first cycle of a phase, so it takes effect at once
   // and a one-cycle phase can still flag last
   assign remaining = load ? len - 1'b1 : cnt_q;
   assign last      = (remaining == '0);

   always_ff @(posedge ref_clk) begin
      if (!rst_n) begin
         cnt_q <= '0;
      end else if (remaining != '0) begin
         cnt_q <= remaining - 1'b1;
      end else begin
         cnt_q <= '0;
      end
   end

endmodule

// File: design/hyper_data_shifter.sv
// Byte serializer for command and write data plus read assembler; read bytes count only when rwds is high
`timescale 1ns/1ns

module hyper_data_shifter (
   input  logic                              ref_clk,
   input  logic                              rst_n,
   input  logic                              load_ca,
   input  logic                              write,
   input  logic [hyper_regs_pkg::DATA_W-1:0] addr,
   input  logic [hyper_regs_pkg::DATA_W-1:0] wdata,
   input  hyper_bus_pkg::phase_e             phase,
   input  logic                              shift_en,
   input  logic [7:0]                        dq_i,
   input  logic                              rwds_i,
   output logic [7:0]                        dq_o,
   output logic [hyper_regs_pkg::DATA_W-1:0] rdata_word,
   output logic                              rdata_valid
);

   localparam int unsigned CA_W = hyper_bus_pkg::CA_BYTES * 8;
   localparam int unsigned SR_W = (hyper_bus_pkg::CA_BYTES + hyper_bus_pkg::DATA_BYTES) * 8;
   localparam int unsigned BC_W = $clog2(hyper_bus_pkg::DATA_BYTES);

   logic [CA_W-1:0] ca_word;
   logic [SR_W-1:0] sr_q;
   logic            wr_q;
   logic            capture;
   logic [BC_W-1:0] bcnt_q;

   // -------------------------------------------------------------------------
   // Transmit path
   // -------------------------------------------------------------------------

   // Bit 47 high marks a read, the upper address bits stay zero
   assign ca_word = {~write, {(CA_W - 1 - hyper_regs_pkg::DATA_W){1'b0}}, addr};

   // Command bytes go first, the write word follows after the latency gap
   always_ff @(posedge ref_clk) begin
      if (load_ca) sr_q <= {ca_word, wdata};
      else if (shift_en) sr_q <= {sr_q[SR_W-9:0], 8'h00};
   end

   assign dq_o = sr_q[SR_W-1 -: 8];

   // -------------------------------------------------------------------------
   // Receive path
   // -------------------------------------------------------------------------

   assign capture = (phase == hyper_bus_pkg::PH_DATA) && !wr_q && rwds_i;

   always_ff @(posedge ref_clk) begin
      if (!rst_n) begin
         wr_q        <= 1'b0;
         bcnt_q      <= '0;
         rdata_valid <= 1'b0;
      end else begin
         if (load_ca) wr_q <= write;
         if (load_ca) bcnt_q <= '0;
         else if (capture) bcnt_q <= bcnt_q + 1'b1;
         // Pulses in the cycle after the fourth byte lands
         rdata_valid <= capture && (bcnt_q == BC_W'(hyper_bus_pkg::DATA_BYTES - 1));
      end
   end

   // Most significant byte arrives first
   always_ff @(posedge ref_clk) begin
      if (capture) rdata_word <= {rdata_word[hyper_regs_pkg::DATA_W-9:0], dq_i};
   end

endmodule

// File: design/hyper_regs_pkg.sv
// APB register map of the HyperBus master; 8-bit offsets, 32-bit data, no byte strobes
package hyper_regs_pkg;

   // -------------------------------------------------------------------------
   // Bus widths
   // -------------------------------------------------------------------------

   localparam int unsigned ADDR_W = 8;
   localparam int unsigned DATA_W = 32;

   // -------------------------------------------------------------------------
   // Register offsets
   // -------------------------------------------------------------------------

   localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h00;
   localparam logic [ADDR_W-1:0] REG_ADDR   = 8'h04;
   localparam logic [ADDR_W-1:0] REG_WDATA  = 8'h08;
   // Read only, loaded by the read path at the end of a read transfer
   localparam logic [ADDR_W-1:0] REG_RDATA  = 8'h0C;
   localparam logic [ADDR_W-1:0] REG_STATUS = 8'h10;

   // -------------------------------------------------------------------------
   // Field positions
   // -------------------------------------------------------------------------

   // Writing one to the start bit launches a transfer, it reads back as zero
   localparam int unsigned CTRL_START_BIT = 0;
   localparam int unsigned CTRL_WRITE_BIT = 1;

   // Done stays set until the next accepted start
   localparam int unsigned STAT_BUSY_BIT = 0;
   localparam int unsigned STAT_DONE_BIT = 1;

endpackage

// File: design/hyper_top.sv
// Pad boundary of the HyperBus master; board wrapper must add tristate buffers and the clock input buffer
`timescale 1ns/1ns

module hyper_top #(
   parameter int unsigned LATENCY = 6
) (
   input  logic                                ref_clk,
   input  logic                                rst_n,
   // APB slave
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [hyper_regs_pkg::ADDR_W-1:0]   paddr,
   input  logic [hyper_regs_pkg::DATA_W-1:0]   pwdata,
   output logic [hyper_regs_pkg::DATA_W-1:0]   prdata,
   output logic                                pready,
   output logic                                pslverr,
   // HyperBus pads, each bidirectional pin split into in, out and enable
   output logic [7:0]                          hyper_dq_o,
   output logic                                hyper_dq_oe,
   input  logic [7:0]                          hyper_dq_i,
   input  logic                                hyper_rwds_i,
   output logic                                hyper_ck,
   output logic                                hyper_csn,
   output logic                                hyper_reset_n
);

   logic                              start;
   logic                              write;
   logic                              busy;
   logic                              done_pulse;
   logic                              load;
   logic                              load_ca;
   logic                              shift_en;
   logic                              last;
   hyper_bus_pkg::phase_e             phase;
   logic [hyper_regs_pkg::DATA_W-1:0] addr;
   logic [hyper_regs_pkg::DATA_W-1:0] wdata;
   logic [hyper_regs_pkg::DATA_W-1:0] rdata_word;
   logic                              rdata_valid;

   // Memory reset follows the system reset one clock later
   always_ff @(posedge ref_clk) begin
      hyper_reset_n <= rst_n;
   end

   hyper_apb_regs u_regs (
      .ref_clk     (ref_clk),     .rst_n      (rst_n),
      .psel        (psel),        .penable    (penable),
      .pwrite      (pwrite),      .paddr      (paddr),
      .pwdata      (pwdata),      .prdata     (prdata),
      .pready      (pready),      .pslverr    (pslverr),
      .busy        (busy),        .done_pulse (done_pulse),
      .rdata_word  (rdata_word),  .rdata_valid(rdata_valid),
      .start       (start),       .write      (write),
      .addr        (addr),        .wdata      (wdata)
   );

   hyper_xfer_fsm u_fsm (
      .ref_clk (ref_clk),  .rst_n     (rst_n),
      .start   (start),    .write     (write),
      .last    (last),     .busy      (busy),
      .done_pulse(done_pulse), .load  (load),
      .phase   (phase),    .load_ca   (load_ca),
      .shift_en(shift_en), .csn       (hyper_csn),
      .ck      (hyper_ck), .dq_oe     (hyper_dq_oe)
   );

   hyper_cycle_counter #(.LATENCY(LATENCY)) u_cnt (
      .ref_clk(ref_clk), .rst_n(rst_n), .load(load), .phase(phase), .last(last)
   );

   hyper_data_shifter u_shift (
      .ref_clk    (ref_clk),      .rst_n   (rst_n),
      .load_ca    (load_ca),      .write   (write),
      .addr       (addr),         .wdata   (wdata),
      .phase      (phase),        .shift_en(shift_en),
      .dq_i       (hyper_dq_i),   .rwds_i  (hyper_rwds_i),
      .dq_o       (hyper_dq_o),   .rdata_word(rdata_word),
      .rdata_valid(rdata_valid)
   );

endmodule

// File: design/hyper_xfer_fsm.sv
// Transfer sequencer; one word per start, start is only taken in IDLE
`timescale 1ns/1ns

module hyper_xfer_fsm (
   input  logic                  ref_clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  logic                  write,
   input  logic                  last,
   output logic                  busy,
   output logic                  done_pulse,
   output logic                  load,
   output hyper_bus_pkg::phase_e phase,
   output logic                  load_ca,
   output logic                  shift_en,
   output logic                  csn,
   output logic                  ck,
   output logic                  dq_oe
);

   hyper_bus_pkg::xfer_state_e state_q;
   hyper_bus_pkg::xfer_state_e state_d;
   logic                       entry_q;
   logic                       wr_q;
   logic                       sel_d;

   // -------------------------------------------------------------------------
   // Next state
   // -------------------------------------------------------------------------

   // Each bus phase ends on the counter's last cycle
   always_comb begin
      state_d = state_q;
      case (state_q)
         hyper_bus_pkg::IDLE: if (start) state_d = hyper_bus_pkg::CMD;
         hyper_bus_pkg::CMD:  if (last) state_d = hyper_bus_pkg::LAT;
         hyper_bus_pkg::LAT:  if (last) state_d = hyper_bus_pkg::DATA;
         hyper_bus_pkg::DATA: if (last) state_d = hyper_bus_pkg::DONE;
         default:             state_d = hyper_bus_pkg::IDLE;
      endcase
   end

   // Chip select is active for every bus phase but not for DONE
   assign sel_d = (state_d == hyper_bus_pkg::CMD) || (state_d == hyper_bus_pkg::LAT) ||
                  (state_d == hyper_bus_pkg::DATA);

   always_ff @(posedge ref_clk) begin
      if (!rst_n) begin
         state_q <= hyper_bus_pkg::IDLE;
         entry_q <= 1'b0;
         wr_q    <= 1'b0;
         ck      <= 1'b0;
      end else begin
         state_q <= state_d;
         // Flags the first cycle of each phase so the counter reloads
         entry_q <= sel_d && (state_d != state_q);
         if (load_ca) wr_q <= write;
         // Clock runs only under chip select and parks low
         ck <= sel_d ? ~ck : 1'b0;
      end
   end

   // -------------------------------------------------------------------------
   // Outputs decoded from the current state
   // -------------------------------------------------------------------------

   always_comb begin
      case (state_q)
         hyper_bus_pkg::LAT:  phase = hyper_bus_pkg::PH_LAT;
         hyper_bus_pkg::DATA: phase = hyper_bus_pkg::PH_DATA;
         default:             phase = hyper_bus_pkg::PH_CMD;
      endcase
   end

   assign load       = entry_q;
   assign load_ca    = (state_q == hyper_bus_pkg::IDLE) && start;
   assign busy       = (state_q != hyper_bus_pkg::IDLE);
   assign done_pulse = (state_q == hyper_bus_pkg::DONE);
   assign csn        = !((state_q == hyper_bus_pkg::CMD) || (state_q == hyper_bus_pkg::LAT) ||
                         (state_q == hyper_bus_pkg::DATA));

   // The master owns dq for the command bytes and for write data only
   assign shift_en = (state_q == hyper_bus_pkg::CMD) ||
                     ((state_q == hyper_bus_pkg::DATA) && wr_q);
   assign dq_oe    = shift_en;

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the HyperBus testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_hyper_top -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
   exit 0
fi
echo "Simulation reported failure"
exit 1

// File: sim/hyper_mem_model.sv
// SDR HyperRAM model; LATENCY must match the DUT and unwritten words read as address ^ 0xA5A5A5A5
`timescale 1ns/1ns

module hyper_mem_model #(
   parameter int unsigned LATENCY = 6
) (
   input  logic       ref_clk,
   input  logic       rst_n,
   input  logic       csn,
   input  logic [7:0] dq_in,
   input  logic       dq_oe,
   output logic [7:0] dq_out,
   output logic       rwds,
   output int         errors
);

   localparam int unsigned DATA_START = hyper_bus_pkg::CA_BYTES + LATENCY;
   localparam int unsigned DATA_END   = DATA_START + hyper_bus_pkg::DATA_BYTES;

   logic [31:0] mem [logic [31:0]];
   logic [47:0] ca;
   logic [31:0] word;
   int unsigned idx;

   initial begin
      errors = 0;
      dq_out <= 8'h00;
      rwds   <= 1'b0;
   end

   // Cycle index counts the clocks of the current chip select window
   always @(posedge ref_clk) begin
      if (!rst_n || csn) begin
         idx = 0;
         dq_out <= 8'h00;
         rwds   <= 1'b0;
      end else begin
         if (idx < hyper_bus_pkg::CA_BYTES) begin
            ca = {ca[39:0], dq_in};
            if (!dq_oe) begin
               $display("Memory model at %0t: dq not driven in command cycle %0d", $time, idx);
               errors++;
            end
         end
         // Last command byte in, so the word for this access is known
         if (idx == hyper_bus_pkg::CA_BYTES - 1) begin
            if (ca[46:32] != 15'h0) begin
               $display("Memory model at %0t: command bits 46 to 32 not zero", $time);
               errors++;
            end
            word = mem.exists(ca[31:0]) ? mem[ca[31:0]] : (ca[31:0] ^ 32'hA5A5_A5A5);
         end
         if (!ca[47] && idx >= DATA_START && idx < DATA_END) begin
            word = {word[23:0], dq_in};
            if (idx == DATA_END - 1) mem[ca[31:0]] = word;
         end
         // Read bytes are set up one clock ahead of the edge that samples them
         if (ca[47] && idx + 1 >= DATA_START && idx + 1 < DATA_END) begin
            dq_out <= word[31 - 8 * (idx + 1 - DATA_START) -: 8];
            rwds   <= 1'b1;
         end else begin
            dq_out <= 8'h00;
            rwds   <= 1'b0;
         end
         idx++;
      end
   end

endmodule

// File: sim/hyper_patterns.txt
# Columns: code, address in hex, data in hex
# W addr data writes a word, R addr expect reads and compares, E off expects pslverr
W 00000100 12345678
R 00000100 12345678
R 00000200 A5A5A7A5
W 00001000 DEADBEEF
W 00002004 0F1E2D3C
R 00001000 DEADBEEF
R 00002004 0F1E2D3C
E 14
E 02
E FF
R 80000000 25A5A5A5
R FFFFFFFC 5A5A5A59
W FFFFFFFC 80000001
R FFFFFFFC 80000001
W 00000100 00000000
R 00000100 00000000
R 12345678 B791F3DD
E 20

// File: sim/tb_clock_gen.sv
// Free running testbench clock that starts low; the default half period gives 10 ns cycles
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int HALF_PERIOD = 5
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

endmodule

// File: sim/tb_hyper_top.sv
// HyperBus master testbench; run from the project root so sim/hyper_patterns.txt is found
`timescale 1ns/1ns

module tb_hyper_top;

   localparam int unsigned LATENCY    = 6;
   localparam int unsigned POLL_LIMIT = 40;
   localparam int unsigned RUN_LIMIT  = 100000;
   localparam int unsigned CA         = hyper_bus_pkg::CA_BYTES;
   localparam int unsigned DB         = hyper_bus_pkg::DATA_BYTES;

   logic        ref_clk;
   logic        rst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [7:0]  dq_o;
   logic        dq_oe;
   logic [7:0]  dq_i;
   logic        rwds;
   logic        ck;
   logic        csn;
   logic        mem_reset_n;
   int          model_errors;

   int          errors = 0;
   int          pin_errors = 0;
   int unsigned started = 0;
   int unsigned seen = 0;
   logic        xfer_write = 1'b0;
   logic        timed_out = 1'b0;

   tb_clock_gen u_clk (.clk(ref_clk));

   hyper_top #(.LATENCY(LATENCY)) u_dut (
      .ref_clk(ref_clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .hyper_dq_o(dq_o), .hyper_dq_oe(dq_oe), .hyper_dq_i(dq_i), .hyper_rwds_i(rwds),
      .hyper_ck(ck), .hyper_csn(csn), .hyper_reset_n(mem_reset_n)
   );

   hyper_mem_model #(.LATENCY(LATENCY)) u_mem (
      .ref_clk(ref_clk), .rst_n(rst_n), .csn(csn), .dq_in(dq_o), .dq_oe(dq_oe),
      .dq_out(dq_i), .rwds(rwds), .errors(model_errors)
   );

   // ------------------------------------------------------------------------
   // Pin monitor that samples on the falling edge where outputs have settled
   // ------------------------------------------------------------------------

   int unsigned busy_cycles = 0;
   int unsigned csn_cycles = 0;
   int unsigned oe_cycles = 0;
   logic        prev_busy = 1'b0;
   logic        prev_ck = 1'b0;
   logic        exp_oe;

   always @(negedge ref_clk) begin
      if (rst_n) begin
         if (csn) begin
            if (ck !== 1'b0) begin
               $display("Error at %0t: hyper_ck expected 0 got %b", $time, ck);
               pin_errors++;
            end
            if (dq_oe !== 1'b0) begin
               $display("Error at %0t: hyper_dq_oe expected 0 got %b", $time, dq_oe);
               pin_errors++;
            end
         end else begin
            // Command bytes and write data are driven, the latency gap never is
            exp_oe = (csn_cycles < CA) || (csn_cycles >= CA + LATENCY && xfer_write);
            if (dq_oe !== exp_oe) begin
               $display("Error at %0t: hyper_dq_oe expected %b got %b", $time, exp_oe, dq_oe);
               pin_errors++;
            end
            if (ck === prev_ck) begin
               $display("hyper_ck failed to toggle at %0t while chip select was low", $time);
               pin_errors++;
            end
            csn_cycles++;
            if (dq_oe) oe_cycles++;
         end
         if (u_dut.busy) busy_cycles++;
         else if (prev_busy) begin
            if (busy_cycles != CA + LATENCY + DB + 1 || csn_cycles != CA + LATENCY + DB ||
                oe_cycles != (xfer_write ? CA + DB : CA)) begin
               $display("Error at %0t: busy/csn/oe cycles expected %0d/%0d/%0d got %0d/%0d/%0d",
                        $time, CA + LATENCY + DB + 1, CA + LATENCY + DB,
                        xfer_write ? CA + DB : CA, busy_cycles, csn_cycles, oe_cycles);
               pin_errors++;
            end
            seen++;
            busy_cycles = 0;
            csn_cycles  = 0;
            oe_cycles   = 0;
         end
         prev_busy = u_dut.busy;
         prev_ck   = ck;
      end
   end

   // ------------------------------------------------------------------------
   // APB and transfer tasks
   // ------------------------------------------------------------------------

   task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
      $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
   endtask

   // Setup cycle, then access cycle; returns right after the accepting edge
   task automatic apb_access(input logic wr, input logic [7:0] a, input logic [31:0] d,
                             output logic [31:0] rd, output logic err);
      @(posedge ref_clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= a;
      pwdata  <= d;
      @(posedge ref_clk);
      penable <= 1'b1;
      @(negedge ref_clk);
      rd  = prdata;
      err = pslverr;
      if (pready !== 1'b1) mismatch("pready", 1, pready);
      @(posedge ref_clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic reg_write(input logic [7:0] a, input logic [31:0] d);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b1, a, d, rd, err);
      if (err !== 1'b0) mismatch("pslverr", 0, err);
   endtask

   task automatic reg_read(input logic [7:0] a, output logic [31:0] rd);
      logic err;
      apb_access(1'b0, a, 32'h0, rd, err);
      if (err !== 1'b0) mismatch("pslverr", 0, err);
   endtask

   task automatic launch(input logic wr, input logic [31:0] a, input logic [31:0] d);
      logic [31:0] ctrl;
      logic [31:0] st;
      logic [7:0]  first_byte;
      ctrl = '0;
      ctrl[hyper_regs_pkg::CTRL_START_BIT] = 1'b1;
      ctrl[hyper_regs_pkg::CTRL_WRITE_BIT] = wr;
      // Bit 47 leads the command word and is set only for a read
      first_byte = wr ? 8'h00 : 8'h80;
      reg_write(hyper_regs_pkg::REG_ADDR, a);
      if (wr) reg_write(hyper_regs_pkg::REG_WDATA, d);
      xfer_write = wr;
      reg_write(hyper_regs_pkg::REG_CTRL, ctrl);
      // First cycle after the accepting edge carries the leading command byte
      @(negedge ref_clk);
      if (csn !== 1'b0) mismatch("hyper_csn", 0, csn);
      if (u_dut.busy !== 1'b1) mismatch("busy", 1, u_dut.busy);
      if (dq_o !== first_byte) mismatch("hyper_dq_o", first_byte, dq_o);
      started++;
      reg_read(hyper_regs_pkg::REG_STATUS, st);
      if (st[hyper_regs_pkg::STAT_BUSY_BIT] !== 1'b1) mismatch("status busy", 1, st);
      if (st[hyper_regs_pkg::STAT_DONE_BIT] !== 1'b0) mismatch("status done", 0, st);
   endtask

   task automatic wait_done();
      logic [31:0] st;
      int unsigned polls;
      st    = '0;
      polls = 0;
      while (!st[hyper_regs_pkg::STAT_DONE_BIT] && polls < POLL_LIMIT) begin
         reg_read(hyper_regs_pkg::REG_STATUS, st);
         polls++;
      end
      if (!st[hyper_regs_pkg::STAT_DONE_BIT]) begin
         $display("Timeout: done never set after %0d status reads at %0t", polls, $time);
         timed_out = 1'b1;
      end else begin
         if (st[hyper_regs_pkg::STAT_BUSY_BIT] !== 1'b0) mismatch("status busy", 0, st);
         // Done is sticky until the next start
         reg_read(hyper_regs_pkg::REG_STATUS, st);
         if (st[hyper_regs_pkg::STAT_DONE_BIT] !== 1'b1) mismatch("status done", 1, st);
      end
   endtask

   task automatic check_rdata(input logic [31:0] exp);
      logic [31:0] rd;
      reg_read(hyper_regs_pkg::REG_RDATA, rd);
      if (rd !== exp) mismatch("rdata", exp, rd);
   endtask

   task automatic idle_gap();
      int unsigned gap;
      gap = $urandom % 8;
      repeat (gap) @(posedge ref_clk);
   endtask

   task automatic skip_line(input int fd);
      int          c;
      int unsigned k;
      c = 0;
      k = 0;
      while (c != "\n" && c != -1 && k < 256) begin
         c = $fgetc(fd);
         k++;
      end
   endtask

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------

   initial begin : stimulus
      int          fd;
      int          n;
      logic [7:0]  code;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] rd;
      logic        err;
      logic        eof;
      rst_n   <= 1'b0;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      void'($urandom(94012));
      repeat (3) @(posedge ref_clk);
      @(negedge ref_clk);
      if (mem_reset_n !== 1'b0) mismatch("hyper_reset_n", 0, mem_reset_n);
      repeat (2) @(posedge ref_clk);
      rst_n <= 1'b1;
      @(negedge ref_clk);
      if (csn !== 1'b1) mismatch("hyper_csn", 1, csn);
      if (ck !== 1'b0) mismatch("hyper_ck", 0, ck);
      if (dq_oe !== 1'b0) mismatch("hyper_dq_oe", 0, dq_oe);
      if (pslverr !== 1'b0) mismatch("pslverr", 0, pslverr);
      @(negedge ref_clk);
      if (mem_reset_n !== 1'b1) mismatch("hyper_reset_n", 1, mem_reset_n);
      reg_read(hyper_regs_pkg::REG_STATUS, rd);
      if (rd !== 32'h0) mismatch("status", 0, rd);

      fd  = $fopen("sim/hyper_patterns.txt", "r");
      eof = (fd == 0);
      if (fd == 0) begin
         $display("Could not open the pattern file sim/hyper_patterns.txt");
         errors++;
      end
      while (!eof && !timed_out) begin
         n = $fscanf(fd, " %c", code);
         if (n != 1) eof = 1'b1;
         else if (code == "#") skip_line(fd);
         else if (code == "W" || code == "R") begin
            n = $fscanf(fd, " %h %h", a, d);
            if (n != 2) begin
               $display("Pattern line with code %c lacks its address or data", code);
               errors++;
            end
            launch(code == "W", a, d);
            wait_done();
            if (code == "R" && !timed_out) check_rdata(d);
            idle_gap();
         end else if (code == "E") begin
            n = $fscanf(fd, " %h", a);
            if (n != 1) begin
               $display("Pattern line with code %c lacks its offset", code);
               errors++;
            end
            apb_access(1'b0, a[7:0], 32'h0, rd, err);
            if (err !== 1'b1) mismatch("pslverr", 1, err);
            apb_access(1'b1, a[7:0], 32'hFFFF_FFFF, rd, err);
            if (err !== 1'b1) mismatch("pslverr", 1, err);
            idle_gap();
         end else begin
            $display("Unknown pattern code %c in the pattern file", code);
            errors++;
            skip_line(fd);
         end
      end
      if (fd != 0) $fclose(fd);

      // A second start during a write is refused and the write still lands
      if (!timed_out) begin
         launch(1'b1, 32'h0000_0400, 32'hCAFE_F00D);
         apb_access(1'b1, hyper_regs_pkg::REG_CTRL, 32'h1 << hyper_regs_pkg::CTRL_START_BIT,
                    rd, err);
         if (err !== 1'b1) mismatch("pslverr", 1, err);
         wait_done();
      end
      if (!timed_out) begin
         launch(1'b0, 32'h0000_0400, 32'h0);
         wait_done();
         if (!timed_out) check_rdata(32'hCAFE_F00D);
      end

      repeat (3) @(posedge ref_clk);
      if (!timed_out && seen != started) begin
         $display("Pin monitor saw %0d transfers end but %0d were started", seen, started);
         errors++;
      end
      $display("Error counts: stimulus %0d, pins %0d, memory model %0d",
               errors, pin_errors, model_errors);
      if (errors == 0 && pin_errors == 0 && model_errors == 0 && !timed_out) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (RUN_LIMIT) @(posedge ref_clk);
      $display("Timeout: the run went past %0d clock cycles", RUN_LIMIT);
      $display("=== FAIL ===");
      $finish;
   end

endmodule
